/* dv/tb_apb_bridge.sv */
`timescale 1ns/1ps
`include "apb_bridge_cfg.svh"

module tb_apb_bridge;

    // Cycle limit for any single wait
    localparam int MAX_WAIT = 20;
    // Edge count from edge 0 to the cycle with pready high
    localparam int PREADY_EDGE = 3;

    logic                  clk;
    logic                  reset;
    logic [`BR_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`BR_DATA_W-1:0] pwdata;
    logic                  pdebug;
    logic                  pready;
    logic [`BR_DATA_W-1:0] prdata;
    logic                  pslverr;

    // Expected register contents
    logic [`BR_DATA_W-1:0] ref_regs [`BR_REG_COUNT];

    tb_clk_gen clk_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    apb_bridge_top apb_bridge_top_i (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pdebug  (pdebug),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

    // --------------------------------------------------
    // Checking
    // --------------------------------------------------
    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    task automatic stop_on_error(input string what);
        $display("Error: %s", what);
        $display("Test failed");
        $fatal(1, "%s", what);
    endtask

    // Reset is only settled once the first edge has passed
    task automatic wait_reset_release();
        int n;
        n = 0;
        do
        begin
            @(posedge clk);
            #1;
            n++;
        end
        while ((reset !== 1'b0) && (n < MAX_WAIT));
        if (reset !== 1'b0)
            stop_on_error("reset was never released");
    endtask

    // --------------------------------------------------
    // APB driver
    // --------------------------------------------------
    // Starts and ends 1 ns after a rising edge
    task automatic apb_transfer(input logic write, input logic [`BR_ADDR_W-1:0] addr,
                                input logic [31:0] wdata, input logic debug,
                                output logic [31:0] rdata, output logic err,
                                output int cycles);
        // Setup phase
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        pdebug  = debug;
        // Edge 0 samples psel
        @(posedge clk);
        #1;
        penable = 1'b1;
        cycles  = 0;
        while (!pready && cycles < MAX_WAIT)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!pready)
            stop_on_error("pready did not rise within the wait limit");
        // pslverr only valid alongside pready
        rdata = prdata;
        err   = pslverr;
        // Transfer completes on the next edge
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [`BR_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic debug, output logic [31:0] rdata,
                             output logic err, output int cycles);
        apb_transfer(1'b1, addr, data, debug, rdata, err, cycles);
    endtask

    task automatic apb_read(input logic [`BR_ADDR_W-1:0] addr, input logic debug,
                            output logic [31:0] rdata, output logic err, output int cycles);
        apb_transfer(1'b0, addr, '0, debug, rdata, err, cycles);
    endtask

    // Runs one access and checks it against the expected bank
    task automatic access_and_check(input string name, input logic write, input int index,
                                    input logic [31:0] wdata, input logic debug,
                                    output int cycles);
        logic [31:0]           rdata;
        logic                  err;
        logic                  exp_err;
        logic [31:0]           exp_data;
        logic [`BR_ADDR_W-1:0] addr;
        addr = `BR_ADDR_W'(index << 2);
        // Out of range, or protected without the debug flag
        exp_err = (index >= `BR_REG_COUNT) || ((index >= `BR_PROT_BASE) && !debug);
        // Writes and rejected accesses return zero
        if (write || exp_err)
            exp_data = '0;
        else
            exp_data = ref_regs[index];
        if (write)
            apb_write(addr, wdata, debug, rdata, err, cycles);
        else
            apb_read(addr, debug, rdata, err, cycles);
        check_equal({name, " pslverr"}, 32'(exp_err), 32'(err));
        check_equal({name, " prdata"}, exp_data, rdata);
        if (write && !exp_err)
            ref_regs[index] = wdata;
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic reset_values();
        int cycles;
        for (int i = 0; i < `BR_PROT_BASE; i++)
            access_and_check("reset_values", 1'b0, i, '0, 1'b0, cycles);
    endtask

    task automatic write_read_back();
        int cycles;
        for (int i = 0; i < `BR_PROT_BASE; i++)
        begin
            access_and_check("write_read_back", 1'b1, i, $urandom(), 1'b0, cycles);
            // Fixed latency, nothing stalls
            check_equal("write_read_back pready edge", PREADY_EDGE, cycles);
        end
        for (int i = 0; i < `BR_PROT_BASE; i++)
        begin
            access_and_check("write_read_back", 1'b0, i, '0, 1'b0, cycles);
            check_equal("write_read_back pready edge", PREADY_EDGE, cycles);
        end
    endtask

    task automatic protected_access();
        int cycles;
        for (int i = `BR_PROT_BASE; i < `BR_REG_COUNT; i++)
        begin
            access_and_check("protected_access", 1'b0, i, '0, 1'b0, cycles);
            access_and_check("protected_access", 1'b1, i, $urandom(), 1'b0, cycles);
            // Value must be unchanged by the rejected write
            access_and_check("protected_access", 1'b0, i, '0, 1'b1, cycles);
        end
    endtask

    task automatic debug_access();
        int cycles;
        for (int i = `BR_PROT_BASE; i < `BR_REG_COUNT; i++)
            access_and_check("debug_access", 1'b1, i, $urandom(), 1'b1, cycles);
        for (int i = `BR_PROT_BASE; i < `BR_REG_COUNT; i++)
            access_and_check("debug_access", 1'b0, i, '0, 1'b1, cycles);
    endtask

    task automatic decode_error();
        int cycles;
        int bad_index [4];
        bad_index = '{16, 17, 255, 16383};
        foreach (bad_index[k])
        begin
            access_and_check("decode_error", 1'b0, bad_index[k], '0, 1'b0, cycles);
            access_and_check("decode_error", 1'b0, bad_index[k], '0, 1'b1, cycles);
            access_and_check("decode_error", 1'b1, bad_index[k], $urandom(), 1'b1, cycles);
            // Low index bits alias a real register, which must stay untouched
            access_and_check("decode_error", 1'b0, bad_index[k] % 16, '0, 1'b1, cycles);
        end
    endtask

    // Next setup phase starts right after each completion
    task automatic back_to_back();
        int   cycles;
        int   index;
        logic write;
        logic debug;
        for (int n = 0; n < 40; n++)
        begin
            index = int'($urandom() % 16);
            write = 1'($urandom() % 2);
            debug = 1'($urandom() % 2);
            access_and_check("back_to_back", write, index, $urandom(), debug, cycles);
        end
    endtask

    // --------------------------------------------------
    // Sequence
    // --------------------------------------------------
    initial
    begin
        void'($urandom(32'h3a7cff60));
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        pdebug  = 1'b0;
        for (int i = 0; i < `BR_REG_COUNT; i++)
            ref_regs[i] = '0;
        wait_reset_release();
        reset_values();
        write_read_back();
        protected_access();
        debug_access();
        decode_error();
        back_to_back();
        $display("Test passed");
        $finish;
    end

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen
(
    output logic clk,
    output logic reset
);

    // 4 ns period
    localparam int HALF_PERIOD = 2;

    initial
    begin
        clk = 1'b0;
        forever
            #HALF_PERIOD clk = ~clk;
    end

    // Reset held over the first three rising edges
    initial
    begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* files.f */
+incdir+src
src/apb_bridge_pkg.sv
src/apb_master_agent.sv
src/pkt_slave_agent.sv
src/reg_bank.sv
src/apb_bridge_top.sv
dv/tb_clk_gen.sv
dv/tb_apb_bridge.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_apb_bridge --Mdir obj_dir -o tb_sim

out=$(./obj_dir/tb_sim) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -q "^Test passed$"

/* src/apb_bridge_cfg.svh */
`ifndef APB_BRIDGE_CFG_SVH
`define APB_BRIDGE_CFG_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define BR_ADDR_W       16
`define BR_DATA_W       32
// One byte enable per data byte
`define BR_BE_W         (`BR_DATA_W / 8)
// Word index drops the two byte-offset bits
`define BR_IDX_W        (`BR_ADDR_W - 2)

// --------------------------------------------------
// Packet word
// --------------------------------------------------
// Command fields take 59 bits, rounded up to a 64-bit word
`define BR_PKT_W        64
`define BR_ID_W         4
// ID stamped into every command by the APB master agent
`define BR_SRC_ID       4'd5

// --------------------------------------------------
// Register bank
// --------------------------------------------------
`define BR_REG_COUNT    16
// Indices from here upward need the debug flag
`define BR_PROT_BASE    12

`endif

/* src/apb_bridge_pkg.sv */
`include "apb_bridge_cfg.svh"

package apb_bridge_pkg;

    // --------------------------------------------------
    // Response status
    // --------------------------------------------------
    // Upper bit set means error, as on AXI
    typedef enum logic [1:0]
    {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_status_e;

    // --------------------------------------------------
    // Packet word views
    // --------------------------------------------------
    // Command as sent by the APB master agent
    typedef struct packed
    {
        // Unused top bits, always zero
        logic [`BR_PKT_W-`BR_ID_W-3-`BR_BE_W-`BR_ADDR_W-`BR_DATA_W-1:0] pad;
        logic [`BR_ID_W-1:0]   src_id;
        // Debug flag rides in the address sideband
        logic                  debug;
        logic                  write;
        logic                  read;
        logic [`BR_BE_W-1:0]   byteen;
        logic [`BR_ADDR_W-1:0] addr;
        logic [`BR_DATA_W-1:0] wdata;
    } cmd_view_t;

    // Response as returned by the packet slave agent
    typedef struct packed
    {
        logic [`BR_PKT_W-`BR_ID_W-2-`BR_DATA_W-1:0] pad;
        // Echo of the command source ID
        logic [`BR_ID_W-1:0]   dest_id;
        resp_status_e          status;
        logic [`BR_DATA_W-1:0] rdata;
    } rsp_view_t;

    // Same word, decoded per direction
    typedef union packed
    {
        cmd_view_t cmd;
        rsp_view_t rsp;
    } pkt_word_u;

endpackage

/* src/apb_bridge_top.sv */
`timescale 1ns/1ps
`include "apb_bridge_cfg.svh"

module apb_bridge_top
    import apb_bridge_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // APB port
    input  logic [`BR_ADDR_W-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`BR_DATA_W-1:0] pwdata,
    input  logic                  pdebug,
    output logic                  pready,
    output logic [`BR_DATA_W-1:0] prdata,
    output logic                  pslverr
);

    // --------------------------------------------------
    // Internal wiring
    // --------------------------------------------------
    // Command path
    logic                  cp_valid;
    logic                  cp_ready;
    logic [`BR_PKT_W-1:0]  cp_data;
    // Response path
    logic                  rp_valid;
    logic [`BR_PKT_W-1:0]  rp_data;
    // Register path
    logic                  reg_en;
    logic                  reg_write;
    logic [`BR_IDX_W-1:0]  reg_index;
    logic [`BR_DATA_W-1:0] reg_wdata;
    logic                  reg_debug;
    logic [`BR_DATA_W-1:0] reg_rdata;
    resp_status_e          reg_status;

    // APB side, builds commands and completes transfers
    apb_master_agent master_agent_i (
        .clk      (clk),
        .reset    (reset),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .pdebug   (pdebug),
        .pready   (pready),
        .prdata   (prdata),
        .pslverr  (pslverr),
        .cp_valid (cp_valid),
        .cp_ready (cp_ready),
        .cp_data  (cp_data),
        .rp_valid (rp_valid),
        .rp_data  (rp_data)
    );

    // Runs one register access per command
    pkt_slave_agent slave_agent_i (
        .clk        (clk),
        .reset      (reset),
        .cp_valid   (cp_valid),
        .cp_ready   (cp_ready),
        .cp_data    (cp_data),
        .rp_valid   (rp_valid),
        .rp_data    (rp_data),
        .reg_en     (reg_en),
        .reg_write  (reg_write),
        .reg_index  (reg_index),
        .reg_wdata  (reg_wdata),
        .reg_debug  (reg_debug),
        .reg_rdata  (reg_rdata),
        .reg_status (reg_status)
    );

    reg_bank reg_bank_i (
        .clk        (clk),
        .reset      (reset),
        .reg_en     (reg_en),
        .reg_write  (reg_write),
        .reg_index  (reg_index),
        .reg_wdata  (reg_wdata),
        .reg_debug  (reg_debug),
        .reg_rdata  (reg_rdata),
        .reg_status (reg_status)
    );

endmodule

/* src/apb_master_agent.sv */
`timescale 1ns/1ps
`include "apb_bridge_cfg.svh"

module apb_master_agent
    import apb_bridge_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // APB slave port
    input  logic [`BR_ADDR_W-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`BR_DATA_W-1:0] pwdata,
    input  logic                  pdebug,
    output logic                  pready,
    output logic [`BR_DATA_W-1:0] prdata,
    output logic                  pslverr,
    // Command packet out
    output logic                  cp_valid,
    input  logic                  cp_ready,
    output logic [`BR_PKT_W-1:0]  cp_data,
    // Response packet in, no ready
    input  logic                  rp_valid,
    input  logic [`BR_PKT_W-1:0]  rp_data
);

    // --------------------------------------------------
    // Controller
    // --------------------------------------------------
    typedef enum logic [1:0]
    {
        IDLE,
        SEND,
        WAIT
    } state_e;

    state_e    state;
    state_e    next_state;
    pkt_word_u cmd_word;
    pkt_word_u rsp_word;
    logic      err_q;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
                if (psel)
                    next_state = SEND;
            // Hold the command until the slave agent takes it
            SEND:
                if (cp_ready)
                    next_state = WAIT;
            // Transfer ends when the APB master drops penable
            // A new setup phase in that cycle starts the next command directly
            WAIT:
                if (!penable)
                    next_state = psel ? SEND : IDLE;
            default:
                next_state = IDLE;
        endcase
    end

    assign cp_valid = (state == SEND);

    // --------------------------------------------------
    // Command build
    // --------------------------------------------------
    // APB holds address and data for the whole transfer
    always_comb
    begin
        cmd_word            = '0;
        cmd_word.cmd.src_id = `BR_SRC_ID;
        cmd_word.cmd.debug  = pdebug;
        cmd_word.cmd.write  = pwrite;
        cmd_word.cmd.read   = !pwrite;
        // Full-word accesses only
        cmd_word.cmd.byteen = '1;
        cmd_word.cmd.addr   = paddr;
        cmd_word.cmd.wdata  = pwdata;
    end

    assign cp_data  = cmd_word;
    assign rsp_word = rp_data;

    // --------------------------------------------------
    // APB completion
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            prdata <= '0;
            err_q  <= 1'b0;
            pready <= 1'b0;
        end
        else
        begin
            // pready follows the response strobe by one cycle
            pready <= rp_valid;
            if (rp_valid)
            begin
                prdata <= rsp_word.rsp.rdata;
                err_q  <= (rsp_word.rsp.status != RESP_OKAY);
            end
        end
    end

    // Error only shown during the completion cycle
    assign pslverr = pready ? err_q : 1'b0;

    // Stalled command must not change under the slave agent
    a_cp_stable: assert property (@(posedge clk) disable iff (reset)
        (cp_valid && !cp_ready) |=> (cp_valid && $stable(cp_data)));

endmodule

/* src/pkt_slave_agent.sv */
`timescale 1ns/1ps
`include "apb_bridge_cfg.svh"

module pkt_slave_agent
    import apb_bridge_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // Command packet in
    input  logic                  cp_valid,
    output logic                  cp_ready,
    input  logic [`BR_PKT_W-1:0]  cp_data,
    // Response packet out, one-cycle strobe
    output logic                  rp_valid,
    output logic [`BR_PKT_W-1:0]  rp_data,
    // Register access
    output logic                  reg_en,
    output logic                  reg_write,
    output logic [`BR_IDX_W-1:0]  reg_index,
    output logic [`BR_DATA_W-1:0] reg_wdata,
    output logic                  reg_debug,
    input  logic [`BR_DATA_W-1:0] reg_rdata,
    input  resp_status_e          reg_status
);

    // --------------------------------------------------
    // Command holding
    // --------------------------------------------------
    pkt_word_u cmd_q;
    pkt_word_u rsp_word;
    logic      held_q;
    logic      accept;

    // One command at a time, so ready is just "nothing held"
    assign cp_ready = !held_q;
    assign accept   = cp_valid && cp_ready;

    // Payload capture on acceptance
    always_ff @(posedge clk)
    begin
        if (accept)
            cmd_q <= cp_data;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            held_q   <= 1'b0;
            rp_valid <= 1'b0;
        end
        else
        begin
            // Register access happens in the cycle right after acceptance
            rp_valid <= reg_en;
            if (accept)
                held_q <= 1'b1;
            // Released once the response strobe has gone out
            else if (rp_valid)
                held_q <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Register access
    // --------------------------------------------------
    // Access cycle is the held cycle before the response
    assign reg_en    = held_q && !rp_valid;
    assign reg_write = cmd_q.cmd.write;
    // Byte offset bits dropped, range left to the bank
    assign reg_index = cmd_q.cmd.addr[`BR_ADDR_W-1:2];
    assign reg_wdata = cmd_q.cmd.wdata;
    assign reg_debug = cmd_q.cmd.debug;

    // --------------------------------------------------
    // Response build
    // --------------------------------------------------
    always_comb
    begin
        rsp_word             = '0;
        rsp_word.rsp.dest_id = cmd_q.cmd.src_id;
        rsp_word.rsp.status  = reg_status;
        rsp_word.rsp.rdata   = reg_rdata;
    end

    // Bank result sampled at the end of the access cycle
    always_ff @(posedge clk)
    begin
        if (reg_en)
            rp_data <= rsp_word;
    end

    // Strobe, never two cycles back to back
    a_rp_single: assert property (@(posedge clk) disable iff (reset)
        rp_valid |=> !rp_valid);

    // Access only for a held command, straight after its acceptance
    a_en_held: assert property (@(posedge clk) disable iff (reset)
        reg_en |-> (held_q && $past(cp_valid && cp_ready)));

endmodule

/* src/reg_bank.sv */
`timescale 1ns/1ps
`include "apb_bridge_cfg.svh"

module reg_bank
    import apb_bridge_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  reg_en,
    input  logic                  reg_write,
    input  logic [`BR_IDX_W-1:0]  reg_index,
    input  logic [`BR_DATA_W-1:0] reg_wdata,
    input  logic                  reg_debug,
    output logic [`BR_DATA_W-1:0] reg_rdata,
    output resp_status_e          reg_status
);

    localparam int SEL_W = $clog2(`BR_REG_COUNT);

    logic [`BR_DATA_W-1:0] regs [`BR_REG_COUNT];
    logic [SEL_W-1:0]      reg_sel;

    // Only meaningful once the range check has passed
    assign reg_sel = reg_index[SEL_W-1:0];

    // --------------------------------------------------
    // Decode and protection
    // --------------------------------------------------
    always_comb
    begin
        // Out of range wins over protection
        if (reg_index >= `BR_REG_COUNT)
            reg_status = RESP_DECERR;
        else if ((reg_index >= `BR_PROT_BASE) && !reg_debug)
            reg_status = RESP_SLVERR;
        else
            reg_status = RESP_OKAY;
    end

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < `BR_REG_COUNT; i++)
                regs[i] <= '0;
        end
        // Rejected writes leave the bank untouched
        else if (reg_en && reg_write && (reg_status == RESP_OKAY))
        begin
            regs[reg_sel] <= reg_wdata;
        end
    end

    // Zero for writes and for any error
    always_comb
    begin
        if ((reg_status == RESP_OKAY) && !reg_write)
            reg_rdata = regs[reg_sel];
        else
            reg_rdata = '0;
    end

    // Index comes from the slave agent's held command
    a_index_known: assert property (@(posedge clk) disable iff (reset)
        reg_en |-> !$isunknown(reg_index));

endmodule
